//--- design/gat_dbg_cfg_pkg.sv
package gat_dbg_cfg_pkg;

  // ********************
  // observed datapath geometry
  // ********************

  localparam int H_NUM_SPARSE_DATA = 12;  // sparse lanes per row.

  localparam int SPPE_LANES      = 16;
  localparam int SPPE_W          = 12;
  localparam int SPPE_PROBE_LANE = 2;    // lane taken by both probes.

  typedef logic [SPPE_W-1:0] sppe_lane_t;

  // ********************
  // probe points
  // ********************

  localparam int WH_ADDR_W = 14;
  localparam logic [WH_ADDR_W-1:0] WH_PROBE_A = 14'd10;
  localparam logic [WH_ADDR_W-1:0] WH_PROBE_B = 14'd20;

  localparam int FEAT_ADDR_W = 16;
  localparam logic [FEAT_ADDR_W-1:0] FEAT_HI_ADDR = 16'd43328;  // start of upper feature region.

  typedef logic [31:0] feat_word_t;

  // softmax event counter.
  localparam int SM_CNT_W = 48;

  localparam logic [31:0] BUILD_ID = 32'd17440405;

endpackage

//--- design/gat_dbg_word_pkg.sv
package gat_dbg_word_pkg;

  typedef logic [31:0] dbg_word_t;
  typedef logic [2:0]  dbg_sel_t;

  // readout selector codes.
  localparam dbg_sel_t SEL_FLAGS  = 3'd0;
  localparam dbg_sel_t SEL_CNT_LO = 3'd1;
  localparam dbg_sel_t SEL_CNT_HI = 3'd2;
  localparam dbg_sel_t SEL_CAP_A  = 3'd3;
  localparam dbg_sel_t SEL_CAP_B  = 3'd4;
  localparam dbg_sel_t SEL_FEAT   = 3'd5;
  localparam dbg_sel_t SEL_ID     = 3'd6;
  localparam dbg_sel_t SEL_BUILD  = 3'd7;

  // ********************
  // flag bit order, msb first
  // ********************

  localparam int NUM_FLAGS = 9;

  localparam int FLAG_SPMM_VLD = 8;
  localparam int FLAG_SPMM_RDY = 7;
  localparam int FLAG_DMVM_VLD = 6;
  localparam int FLAG_DMVM_RDY = 5;
  localparam int FLAG_SM_VLD   = 4;
  localparam int FLAG_SM_RDY   = 3;
  localparam int FLAG_AGGR_VLD = 2;
  localparam int FLAG_AGGR_RDY = 1;
  localparam int FLAG_FEAT_ENA = 0;

  typedef logic [NUM_FLAGS-1:0] stage_flags_t;

endpackage

//--- design/stage_flag_recorder.sv
`timescale 1ns/10ps

module stage_flag_recorder
  import gat_dbg_word_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  stage_flags_t strobe_i,
  output stage_flags_t flags_o
);

  stage_flags_t flags_q;
  stage_flags_t flags_d;

  // ********************
  // sticky set
  // ********************

  // a bit goes high on its strobe and only reset brings it down.
  always_comb begin
    flags_d = flags_q;
    for (int i = 0; i < NUM_FLAGS; i++) begin
      if (strobe_i[i]) begin
        flags_d[i] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags_q <= '0;
    end else begin
      flags_q <= flags_d;
    end
  end

  assign flags_o = flags_q;  // registered record of fired stages.

endmodule

//--- design/sm_event_counter.sv
`timescale 1ns/10ps

module sm_event_counter
  import gat_dbg_cfg_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                sm_vld_i,
  output logic [SM_CNT_W-1:0] count_o
);

  logic [SM_CNT_W-1:0] count_q;

  // wraps to zero past the top of the range.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (sm_vld_i) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign count_o = count_q;

endmodule

//--- design/probe_capture.sv
`timescale 1ns/10ps

module probe_capture #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     trig_i,
  input  payload_t data_i,
  output payload_t data_o
);

  payload_t data_q;

  // ********************
  // capture register
  // ********************

  // each trigger overwrites, so the last match is kept.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_q <= '0;
    end else if (trig_i) begin
      data_q <= data_i;
    end
  end

  assign data_o = data_q;

endmodule

//--- design/debug_readout.sv
`timescale 1ns/10ps

module debug_readout
  import gat_dbg_cfg_pkg::*;
  import gat_dbg_word_pkg::*;
(
  input  dbg_sel_t            sel_i,
  input  stage_flags_t        flags_i,
  input  logic [SM_CNT_W-1:0] count_i,
  input  sppe_lane_t          cap_a_i,
  input  sppe_lane_t          cap_b_i,
  input  feat_word_t          feat_i,
  output dbg_word_t           word_o,
  output dbg_word_t           flags_o
);

  dbg_word_t flags_ext;
  dbg_word_t cnt_lo;
  dbg_word_t cnt_hi;

  assign flags_ext = dbg_word_t'(flags_i);
  assign cnt_lo    = count_i[31:0];
  assign cnt_hi    = dbg_word_t'(count_i[SM_CNT_W-1:32]);  // upper 16 bits.

  // ********************
  // readout mux
  // ********************

  // purely combinational, a new selector shows in the same cycle.
  always_comb begin
    case (sel_i)
      SEL_FLAGS:  word_o = flags_ext;
      SEL_CNT_LO: word_o = cnt_lo;
      SEL_CNT_HI: word_o = cnt_hi;
      SEL_CAP_A:  word_o = dbg_word_t'(cap_a_i);
      SEL_CAP_B:  word_o = dbg_word_t'(cap_b_i);
      SEL_FEAT:   word_o = feat_i;
      SEL_ID:     word_o = dbg_word_t'(H_NUM_SPARSE_DATA);
      SEL_BUILD:  word_o = BUILD_ID;
      default:    word_o = '0;
    endcase
  end

  assign flags_o = flags_ext;  // live flags, independent of sel_i.

endmodule

//--- design/gat_debug_top.sv
`timescale 1ns/10ps

module gat_debug_top
  import gat_dbg_cfg_pkg::*;
  import gat_dbg_word_pkg::*;
(
  input  logic                              clk,
  input  logic                              rst_n,

  input  logic                              spmm_vld_i,
  input  logic                              spmm_rdy_i,
  input  logic                              dmvm_vld_i,
  input  logic                              dmvm_rdy_i,
  input  logic                              sm_vld_i,
  input  logic                              sm_rdy_i,
  input  logic                              aggr_vld_i,
  input  logic                              aggr_rdy_i,

  input  sppe_lane_t [SPPE_LANES-1:0]       sppe_i,
  input  logic       [WH_ADDR_W-1:0]        wh_bram_addra_i,

  input  feat_word_t                        feat_bram_din_i,
  input  logic                              feat_bram_ena_i,
  input  logic       [FEAT_ADDR_W-1:0]      feat_bram_addra_i,

  input  dbg_sel_t                          dbg_sel_i,
  output dbg_word_t                         dbg_word_o,
  output dbg_word_t                         dbg_flags_o
);

  stage_flags_t        strobes;
  stage_flags_t        flags;
  logic [SM_CNT_W-1:0] sm_count;
  logic                trig_a;
  logic                trig_b;
  logic                trig_f;
  sppe_lane_t          probe_lane;
  sppe_lane_t          cap_a_q;
  sppe_lane_t          cap_b_q;
  feat_word_t          feat_q;

  // ********************
  // strobe packing and triggers
  // ********************

  always_comb begin
    strobes                = '0;
    strobes[FLAG_SPMM_VLD] = spmm_vld_i;
    strobes[FLAG_SPMM_RDY] = spmm_rdy_i;
    strobes[FLAG_DMVM_VLD] = dmvm_vld_i;
    strobes[FLAG_DMVM_RDY] = dmvm_rdy_i;
    strobes[FLAG_SM_VLD]   = sm_vld_i;
    strobes[FLAG_SM_RDY]   = sm_rdy_i;
    strobes[FLAG_AGGR_VLD] = aggr_vld_i;
    strobes[FLAG_AGGR_RDY] = aggr_rdy_i;
    strobes[FLAG_FEAT_ENA] = feat_bram_ena_i;
  end

  assign probe_lane = sppe_i[SPPE_PROBE_LANE];

  // probes only count while sparse multiply is ready.
  assign trig_a = spmm_rdy_i && (wh_bram_addra_i == WH_PROBE_A);
  assign trig_b = spmm_rdy_i && (wh_bram_addra_i == WH_PROBE_B);
  assign trig_f = feat_bram_ena_i && (feat_bram_addra_i >= FEAT_HI_ADDR);

  // ********************
  // recorders
  // ********************

  stage_flag_recorder u_flags (
    .clk      (clk),
    .rst_n    (rst_n),
    .strobe_i (strobes),
    .flags_o  (flags)
  );

  sm_event_counter u_sm_cnt (
    .clk      (clk),
    .rst_n    (rst_n),
    .sm_vld_i (sm_vld_i),
    .count_o  (sm_count)
  );

  probe_capture #(.payload_t(sppe_lane_t)) cap_a (
    .clk(clk), .rst_n(rst_n), .trig_i(trig_a), .data_i(probe_lane), .data_o(cap_a_q)
  );

  probe_capture #(.payload_t(sppe_lane_t)) cap_b (
    .clk(clk), .rst_n(rst_n), .trig_i(trig_b), .data_i(probe_lane), .data_o(cap_b_q)
  );

  probe_capture #(.payload_t(feat_word_t)) cap_feat (
    .clk(clk), .rst_n(rst_n), .trig_i(trig_f), .data_i(feat_bram_din_i), .data_o(feat_q)
  );

  debug_readout u_readout (
    .sel_i   (dbg_sel_i),
    .flags_i (flags),
    .count_i (sm_count),
    .cap_a_i (cap_a_q),
    .cap_b_i (cap_b_q),
    .feat_i  (feat_q),
    .word_o  (dbg_word_o),
    .flags_o (dbg_flags_o)
  );

endmodule

//--- dv/gat_debug_properties.sv
`timescale 1ns/10ps

module gat_debug_properties
  import gat_dbg_cfg_pkg::*;
  import gat_dbg_word_pkg::*;
(
  input logic                clk,
  input logic                rst_n,
  input logic                sm_vld_i,
  input logic                trig_f_i,
  input stage_flags_t        flags_i,
  input logic [SM_CNT_W-1:0] count_i,
  input feat_word_t          feat_i
);

  int unsigned err_count = 0;  // assertion failures so far.

  // ********************
  // sticky flags
  // ********************

  a_flags_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    ($past(flags_i) & ~flags_i) == stage_flags_t'(0))
    else begin
      $error("a stage flag fell while out of reset");
      err_count++;
    end

  // ********************
  // counter and capture
  // ********************

  a_count_source: assert property (@(posedge clk) disable iff (!rst_n)
    $changed(count_i) |-> $past(sm_vld_i))
    else begin
      $error("softmax count moved without a softmax valid cycle");
      err_count++;
    end

  a_feat_source: assert property (@(posedge clk) disable iff (!rst_n)
    $changed(feat_i) |-> $past(trig_f_i))  // only the threshold trigger loads it.
    else begin
      $error("feature capture moved without a high-address write");
      err_count++;
    end

endmodule

bind gat_debug_top gat_debug_properties u_props (
  .clk      (clk),
  .rst_n    (rst_n),
  .sm_vld_i (sm_vld_i),
  .trig_f_i (trig_f),
  .flags_i  (flags),
  .count_i  (sm_count),
  .feat_i   (feat_q)
);

//--- dv/gat_debug_tb.sv
`timescale 1ns/10ps

module gat_debug_tb
  import gat_dbg_cfg_pkg::*;
  import gat_dbg_word_pkg::*;
();

  localparam string       GOLDEN_FILE  = "dv/gat_debug_golden.txt";
  localparam int          RESET_CYCLES = 4;
  localparam logic [31:0] SEED         = 32'h73e5e9cf;

  logic                        clk;
  logic                        rst_n;
  logic                        spmm_vld;
  logic                        spmm_rdy;
  logic                        dmvm_vld;
  logic                        dmvm_rdy;
  logic                        sm_vld;
  logic                        sm_rdy;
  logic                        aggr_vld;
  logic                        aggr_rdy;
  sppe_lane_t [SPPE_LANES-1:0] sppe;
  logic [WH_ADDR_W-1:0]        wh_addr;
  feat_word_t                  feat_din;
  logic                        feat_ena;
  logic [FEAT_ADDR_W-1:0]      feat_addr;
  dbg_sel_t                    dbg_sel;
  dbg_word_t                   dbg_word;
  dbg_word_t                   dbg_flags;

  // one entry per golden line.
  logic                   rst_q[$];
  logic [7:0]             stb_q[$];
  sppe_lane_t             lane_q[$];
  logic [WH_ADDR_W-1:0]   wh_q[$];
  logic [FEAT_ADDR_W-1:0] faddr_q[$];
  logic                   fena_q[$];
  feat_word_t             fdata_q[$];
  dbg_sel_t               sel_q[$];
  dbg_word_t              expw_q[$];
  dbg_word_t              expf_q[$];

  int unsigned cycles      = 0;
  int unsigned cycle_limit = 0;

  gat_debug_top uut (
    .clk               (clk),
    .rst_n             (rst_n),
    .spmm_vld_i        (spmm_vld),
    .spmm_rdy_i        (spmm_rdy),
    .dmvm_vld_i        (dmvm_vld),
    .dmvm_rdy_i        (dmvm_rdy),
    .sm_vld_i          (sm_vld),
    .sm_rdy_i          (sm_rdy),
    .aggr_vld_i        (aggr_vld),
    .aggr_rdy_i        (aggr_rdy),
    .sppe_i            (sppe),
    .wh_bram_addra_i   (wh_addr),
    .feat_bram_din_i   (feat_din),
    .feat_bram_ena_i   (feat_ena),
    .feat_bram_addra_i (feat_addr),
    .dbg_sel_i         (dbg_sel),
    .dbg_word_o        (dbg_word),
    .dbg_flags_o       (dbg_flags)
  );

  // ********************
  // clock and timeout
  // ********************

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period.
  end

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit != 0 && cycles > cycle_limit) begin
      fail_stop($sformatf("timeout, golden run not finished after %0d cycles", cycles));
    end
  end

  task automatic fail_stop(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_word(input dbg_word_t exp, input int idx);
    if (dbg_word !== exp) begin
      fail_stop($sformatf("Mismatch dbg_word_o: expected 0x%08h, actual 0x%08h (golden entry %0d)",
                          exp, dbg_word, idx));
    end
  endtask

  task automatic check_flags(input dbg_word_t exp, input int idx);
    if (dbg_flags !== exp) begin
      fail_stop($sformatf("Mismatch dbg_flags_o: expected 0x%08h, actual 0x%08h (golden entry %0d)",
                          exp, dbg_flags, idx));
    end
  endtask

  task automatic check_assertions();
    if (uut.u_props.err_count != 0) begin
      fail_stop("a concurrent assertion on the DUT failed");
    end
  endtask

  // ********************
  // golden file
  // ********************

  task automatic load_golden();
    int          fd;
    int          line_no;
    int          fields;
    string       line;
    logic [31:0] t_rst;
    logic [31:0] t_stb;
    logic [31:0] t_lane;
    logic [31:0] t_wh;
    logic [31:0] t_faddr;
    logic [31:0] t_fena;
    logic [31:0] t_fdata;
    logic [31:0] t_sel;
    logic [31:0] t_expw;
    logic [31:0] t_expf;
    line_no = 0;
    fd = $fopen(GOLDEN_FILE, "r");
    if (fd == 0) begin
      fail_stop({"cannot open the golden file ", GOLDEN_FILE});
    end
    while ($fgets(line, fd) != 0) begin
      line_no++;
      if (line.len() < 2 || line[0] == "#") begin
        continue;  // blank or comment line.
      end
      fields = $sscanf(line, "%b %b %h %h %h %b %h %h %h %h", t_rst, t_stb, t_lane, t_wh,
                       t_faddr, t_fena, t_fdata, t_sel, t_expw, t_expf);
      if (fields != 10) begin
        fail_stop($sformatf("golden file line %0d does not hold ten fields", line_no));
      end
      rst_q.push_back(t_rst[0]);
      stb_q.push_back(t_stb[7:0]);
      lane_q.push_back(sppe_lane_t'(t_lane));
      wh_q.push_back(t_wh[WH_ADDR_W-1:0]);
      faddr_q.push_back(t_faddr[FEAT_ADDR_W-1:0]);
      fena_q.push_back(t_fena[0]);
      fdata_q.push_back(t_fdata);
      sel_q.push_back(dbg_sel_t'(t_sel));
      expw_q.push_back(t_expw);
      expf_q.push_back(t_expf);
    end
    $fclose(fd);
    if (rst_q.size() == 0) begin
      fail_stop("golden file holds no stimulus lines");
    end
  endtask

  task automatic drive_line(input int idx);
    rst_n = rst_q[idx];
    {spmm_vld, spmm_rdy, dmvm_vld, dmvm_rdy, sm_vld, sm_rdy, aggr_vld, aggr_rdy} = stb_q[idx];
    for (int k = 0; k < SPPE_LANES; k++) begin
      sppe[k] = (k == SPPE_PROBE_LANE) ? lane_q[idx] : sppe_lane_t'($urandom);
    end
    wh_addr   = wh_q[idx];
    feat_addr = faddr_q[idx];
    feat_ena  = fena_q[idx];
    feat_din  = fdata_q[idx];
    dbg_sel   = sel_q[idx];
  endtask

  // ********************
  // main sequence
  // ********************

  initial begin
    void'($urandom(SEED));
    rst_n     = 1'b0;
    spmm_vld  = 1'b0;
    spmm_rdy  = 1'b0;
    dmvm_vld  = 1'b0;
    dmvm_rdy  = 1'b0;
    sm_vld    = 1'b0;
    sm_rdy    = 1'b0;
    aggr_vld  = 1'b0;
    aggr_rdy  = 1'b0;
    sppe      = '0;
    wh_addr   = '0;
    feat_din  = '0;
    feat_ena  = 1'b0;
    feat_addr = '0;
    dbg_sel   = SEL_FLAGS;
    load_golden();
    cycle_limit = rst_q.size() + RESET_CYCLES + 10;
    repeat (RESET_CYCLES) @(posedge clk);
    // each entry is checked one falling edge after it was driven.
    for (int i = 0; i < rst_q.size(); i++) begin
      @(negedge clk);
      if (i > 0) begin
        check_word(expw_q[i-1], i - 1);
        check_flags(expf_q[i-1], i - 1);
      end
      check_assertions();
      drive_line(i);
    end
    @(negedge clk);
    check_word(expw_q[rst_q.size()-1], rst_q.size() - 1);
    check_flags(expf_q[rst_q.size()-1], rst_q.size() - 1);
    if (uut.u_props.err_count != 0) begin
      fail_stop("a concurrent assertion on the DUT failed");
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

//--- dv/gat_debug_golden.txt
# rst strobes(spmm_v spmm_r dmvm_v dmvm_r sm_v sm_r aggr_v aggr_r) lane2 wh feat_addr feat_ena
# feat_data sel exp_word exp_flags ; all hex except rst, strobes and feat_ena (binary)
# after reset
1 00000000 000 0000 0000 0 00000000 0 00000000 00000000
1 00000000 000 0000 0000 0 00000000 1 00000000 00000000
1 00000000 000 0000 0000 0 00000000 3 00000000 00000000
1 00000000 000 0000 0000 0 00000000 5 00000000 00000000
1 00000000 000 0000 0000 0 00000000 6 0000000c 00000000
1 00000000 000 0000 0000 0 00000000 7 010a1e95 00000000
1 00000000 000 0000 0000 0 00000000 2 00000000 00000000
1 00000000 000 0000 0000 0 00000000 4 00000000 00000000
# single strobes
1 10000000 000 0000 0000 0 00000000 0 00000100 00000100
1 00000000 000 0000 0000 0 00000000 0 00000100 00000100
1 00010000 000 0000 0000 0 00000000 0 00000120 00000120
1 00000010 000 0000 0000 0 00000000 0 00000124 00000124
1 00000000 000 0000 0000 0 00000000 0 00000124 00000124
1 00000100 000 0000 0000 0 00000000 0 0000012c 0000012c
# softmax valid count
1 00001000 000 0000 0000 0 00000000 1 00000001 0000013c
1 00001000 000 0000 0000 0 00000000 1 00000002 0000013c
1 00000000 000 0000 0000 0 00000000 1 00000002 0000013c
1 00001000 000 0000 0000 0 00000000 1 00000003 0000013c
1 00101000 000 0000 0000 0 00000000 1 00000004 0000017c
1 00000000 000 0000 0000 0 00000000 2 00000000 0000017c
# lane probes
1 00000000 5a3 000a 0000 0 00000000 3 00000000 0000017c
1 01000000 5a3 000a 0000 0 00000000 3 000005a3 000001fc
1 01000000 0c7 0014 0000 0 00000000 4 000000c7 000001fc
1 00000000 3ff 0014 0000 0 00000000 4 000000c7 000001fc
1 00000000 777 000a 0000 0 00000000 3 000005a3 000001fc
1 01000000 111 000b 0000 0 00000000 3 000005a3 000001fc
1 01000000 e42 000a 0000 0 00000000 3 00000e42 000001fc
1 00000000 000 0000 0000 0 00000000 4 000000c7 000001fc
# feature writes around the threshold
1 00000000 000 0000 a93f 1 deadbeef 5 00000000 000001fd
1 00000000 000 0000 a940 0 12345678 5 00000000 000001fd
1 00000000 000 0000 a940 1 cafe0001 5 cafe0001 000001fd
1 00000000 000 0000 0100 1 0badf00d 5 cafe0001 000001fd
1 00000000 000 0000 ffff 1 5eed1234 5 5eed1234 000001fd
1 00000001 000 0000 0000 0 00000000 0 000001ff 000001ff
1 00000000 000 0000 0000 0 00000000 1 00000004 000001ff
# reset in mid-run
0 00000000 000 0000 0000 0 00000000 0 00000000 00000000
1 00000000 000 0000 0000 0 00000000 1 00000000 00000000
1 00000000 000 0000 0000 0 00000000 3 00000000 00000000
1 00000000 000 0000 0000 0 00000000 4 00000000 00000000
1 00000000 000 0000 0000 0 00000000 5 00000000 00000000
1 00000000 000 0000 0000 0 00000000 6 0000000c 00000000
1 00001000 000 0000 0000 0 00000000 1 00000001 00000010

//--- tb.f
design/gat_dbg_cfg_pkg.sv
design/gat_dbg_word_pkg.sv
design/stage_flag_recorder.sv
design/sm_event_counter.sv
design/probe_capture.sv
design/debug_readout.sv
design/gat_debug_top.sv
dv/gat_debug_properties.sv
dv/gat_debug_tb.sv
